/* Bender.yml */
package:
  name: mmm

sources:
  - files:
      - design/mmm_pkg.sv
      - design/mmm_ctrl_if.sv
      - design/mmm_ram_if.sv
      - design/mmm_matrix_ram.sv
      - design/mmm_regs.sv
      - design/mmm_engine.sv
      - design/mmm_top.sv
  - target: simulation
    files:
      - bench/mmm_chk.sv
      - bench/mmm_tb.sv

/* bench/mmm_chk.sv */
`timescale 1ns/1ps

module mmm_chk
    import mmm_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input logic           bvalid,
    input logic           bready,
    input logic           rvalid,
    input logic           rready,
    input logic           start,
    input logic           busy,
    input logic [K_W-1:0] k
);

    int failures = 0;

    // responses hold until the master takes them
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            failures++;
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            failures++;
        end

    start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy)
        else begin
            $error("start pulse while engine busy");
            failures++;
        end

    k_stable: assert property (@(posedge clk) disable iff (!rst_n)
        busy && $past(busy) |-> $stable(k))
        else begin
            $error("k changed during a run");
            failures++;
        end

endmodule

bind mmm_regs mmm_chk chk_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .bvalid (s_axi_bvalid),
    .bready (s_axi_bready),
    .rvalid (s_axi_rvalid),
    .rready (s_axi_rready),
    .start  (ctrl.start),
    .busy   (ctrl.busy),
    .k      (ctrl.k)
);

/* bench/mmm_patterns.hex */
// k, then A (M_ROWS x k), B (k x N_COLS), expected C (M_ROWS x N_COLS), all row-major
// A[0][0] is all ones so row 0 of C wraps
00000004
ffffffff
00000002
00000003
00000004
00000005
00000006
00000007
00000008
00000009
0000000a
0000000b
0000000c
00000001
00000000
00000002
00000000
00000001
00000000
00000001
00000000
00000003
00000001
00000002
00000000
00000001
00000000
00000001
00000000
00000002
00000000
00000001
00000001
00000005
0000000a
00000001
0000000a
00000008
00000013
00000016
00000011
0000001a
0000001a
0000001f
00000022
0000001d
0000002a
0000002a

/* bench/mmm_tb.sv */
`timescale 1ns/1ps

module mmm_tb
    import mmm_pkg::*;
();

    // about 20 cycles per AXI transaction plus four runs at worst-case k
    localparam int TXN_BUDGET  = 260;
    localparam int CYCLE_LIMIT = 20 * TXN_BUDGET + 4 * (C_DEPTH * (MAX_K + 2) + 1) + 500;
    localparam int PAT_WORDS   = 1 + A_DEPTH + B_DEPTH + C_DEPTH;

    logic              clk;
    logic              rst_n;
    logic [AXI_AW-1:0] s_axi_awaddr;
    logic              s_axi_awvalid;
    logic              s_axi_awready;
    logic [DATA_W-1:0] s_axi_wdata;
    logic              s_axi_wvalid;
    logic              s_axi_wready;
    logic [1:0]        s_axi_bresp;
    logic              s_axi_bvalid;
    logic              s_axi_bready;
    logic [AXI_AW-1:0] s_axi_araddr;
    logic              s_axi_arvalid;
    logic              s_axi_arready;
    logic [DATA_W-1:0] s_axi_rdata;
    logic [1:0]        s_axi_rresp;
    logic              s_axi_rvalid;
    logic              s_axi_rready;

    logic [DATA_W-1:0] pat   [PAT_WORDS];
    logic [DATA_W-1:0] a_mem [A_DEPTH];
    logic [DATA_W-1:0] b_mem [B_DEPTH];
    logic [DATA_W-1:0] exp_c [C_DEPTH];
    logic [31:0]       seed;
    int                cycles;
    int                errors;
    int                tests_ok;
    int                tests_bad;
    int                k_list [2] = '{1, MAX_K};

    mmm_top mmm_top_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        @(negedge clk);
        while (!s_axi_awready) @(negedge clk);
        expect_eq("s_axi_wready", 32'h1, s_axi_wready);
        // handshake completes on the next rising edge
        @(negedge clk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid) @(negedge clk);
        resp = s_axi_bresp;
        // response waits one cycle before it is taken
        @(negedge clk);
        s_axi_bready = 1'b1;
        @(negedge clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        @(negedge clk);
        while (!s_axi_arready) @(negedge clk);
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) @(negedge clk);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        // read data waits one cycle before it is taken
        @(negedge clk);
        s_axi_rready = 1'b1;
        @(negedge clk);
        s_axi_rready = 1'b0;
    endtask

    task automatic write_ok(input logic [AXI_AW-1:0] addr, input logic [DATA_W-1:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        expect_eq($sformatf("s_axi_bresp @%h", addr), RESP_OKAY, resp);
    endtask

    task automatic read_check(input logic [AXI_AW-1:0] addr, input logic [DATA_W-1:0] exp,
                              input string name);
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        axi_read(addr, data, resp);
        expect_eq({"s_axi_rresp ", name}, RESP_OKAY, resp);
        expect_eq({"s_axi_rdata ", name}, exp, data);
    endtask

    task automatic random_fill(input int k);
        for (int i = 0; i < M_ROWS * k; i++) begin
            seed     = xorshift32(seed);
            a_mem[i] = seed;
        end
        for (int i = 0; i < k * N_COLS; i++) begin
            seed     = xorshift32(seed);
            b_mem[i] = seed;
        end
    endtask

    // C[r][c] is the low 32 bits of the dot product of row r and column c
    task automatic predict(input int k);
        logic [DATA_W-1:0] sum;
        for (int r = 0; r < M_ROWS; r++) begin
            for (int c = 0; c < N_COLS; c++) begin
                sum = '0;
                for (int i = 0; i < k; i++) begin
                    sum = sum + a_mem[r * k + i] * b_mem[i * N_COLS + c];
                end
                exp_c[r * N_COLS + c] = sum;
            end
        end
    endtask

    task automatic load_and_start(input int k);
        write_ok(REG_K, DATA_W'(k));
        for (int i = 0; i < M_ROWS * k; i++) begin
            write_ok(A_BASE + AXI_AW'(4 * i), a_mem[i]);
        end
        for (int i = 0; i < k * N_COLS; i++) begin
            write_ok(B_BASE + AXI_AW'(4 * i), b_mem[i]);
        end
        write_ok(REG_CTRL, 32'h1);
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        do begin
            axi_read(REG_STATUS, data, resp);
        end while (!data[1]);
        expect_eq("STATUS after run", 32'h2, data);
    endtask

    task automatic check_c();
        for (int i = 0; i < C_DEPTH; i++) begin
            read_check(C_BASE + AXI_AW'(4 * i), exp_c[i], $sformatf("C[%0d]", i));
        end
    endtask

    task automatic illegal_start(input int k);
        write_ok(REG_K, DATA_W'(k));
        write_ok(REG_CTRL, 32'h1);
        // k_err set, done and busy low
        read_check(REG_STATUS, 32'h4, $sformatf("STATUS k=%0d", k));
    endtask

    task automatic finish_test(input string name, input int mark);
        if (errors == mark) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        logic [DATA_W-1:0] rdata;
        logic [1:0]        resp;
        int                mark;
        int                k;
        clk           = 1'b0;
        rst_n         = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        seed          = 32'h883a48a0;
        cycles        = 0;
        errors        = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        $readmemh("bench/mmm_patterns.hex", pat);
        apply_reset();

        mark = errors;
        read_check(REG_K, 32'h0, "K");
        read_check(REG_STATUS, 32'h0, "STATUS");
        read_check(REG_CTRL, 32'h0, "CTRL");
        finish_test("reset state", mark);

        mark = errors;
        write_ok(REG_K, 32'h5);
        read_check(REG_K, 32'h5, "K");
        axi_write(12'h010, 32'hdead_beef, resp);
        expect_eq("s_axi_bresp unmapped", RESP_SLVERR, resp);
        axi_read(12'h010, rdata, resp);
        expect_eq("s_axi_rresp unmapped", RESP_SLVERR, resp);
        expect_eq("s_axi_rdata unmapped", 32'h0, rdata);
        finish_test("register decode", mark);

        // done is still clear here, no run has finished yet
        mark = errors;
        illegal_start(0);
        // reset clears the sticky k_err left by the k=0 case
        apply_reset();
        illegal_start(7);
        finish_test("illegal k", mark);

        mark = errors;
        k = int'(pat[0]);
        for (int i = 0; i < M_ROWS * k; i++) begin
            a_mem[i] = pat[1 + i];
        end
        for (int i = 0; i < k * N_COLS; i++) begin
            b_mem[i] = pat[1 + M_ROWS * k + i];
        end
        for (int i = 0; i < C_DEPTH; i++) begin
            exp_c[i] = pat[1 + (M_ROWS + N_COLS) * k + i];
        end
        load_and_start(k);
        wait_done();
        check_c();
        finish_test("directed multiply", mark);

        foreach (k_list[j]) begin
            mark = errors;
            random_fill(k_list[j]);
            predict(k_list[j]);
            load_and_start(k_list[j]);
            wait_done();
            check_c();
            finish_test($sformatf("random multiply k=%0d", k_list[j]), mark);
        end

        mark = errors;
        random_fill(3);
        predict(3);
        load_and_start(3);
        read_check(REG_STATUS, 32'h1, "STATUS busy");
        axi_write(A_BASE, 32'h1234_5678, resp);
        expect_eq("s_axi_bresp A busy", RESP_SLVERR, resp);
        axi_read(C_BASE, rdata, resp);
        expect_eq("s_axi_rresp C busy", RESP_SLVERR, resp);
        expect_eq("s_axi_rdata C busy", 32'h0, rdata);
        // k and a second start are accepted and ignored during the run
        write_ok(REG_K, DATA_W'(MAX_K));
        write_ok(REG_CTRL, 32'h1);
        wait_done();
        read_check(REG_K, 32'h3, "K after run");
        check_c();
        finish_test("busy protection", mark);

        if (mmm_top_i.regs_i.chk_i.failures != 0) begin
            $display("protocol checker flagged %0d assertion failures",
                     mmm_top_i.regs_i.chk_i.failures);
            errors = errors + mmm_top_i.regs_i.chk_i.failures;
        end

        $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* design/mmm_ctrl_if.sv */
`timescale 1ns/1ps

interface mmm_ctrl_if
    import mmm_pkg::*;
();

    // start is a single-cycle pulse, k holds while busy
    logic           start;
    logic [K_W-1:0] k;
    logic           busy;
    logic           done;

    modport regs (
        output start, k,
        input  busy, done
    );

    modport engine (
        input  start, k,
        output busy, done
    );

endinterface

/* design/mmm_engine.sv */
`timescale 1ns/1ps

module mmm_engine
    import mmm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    mmm_ctrl_if.engine ctrl,
    mmm_ram_if.reader  a_rd,
    mmm_ram_if.reader  b_rd,
    mmm_ram_if.writer  c_wr
);

    engine_state_e     state;
    logic [K_W-1:0]    k_q;
    logic [K_W-1:0]    inner;
    logic [C_AW-1:0]   col;
    logic [C_AW-1:0]   c_idx;
    logic [A_AW-1:0]   a_row;
    logic [B_AW-1:0]   b_off;
    logic              rd_vld;
    logic [DATA_W-1:0] acc;

    // A is packed with stride k, B with stride N_COLS
    assign a_rd.rd_addr = a_row + A_AW'(inner);
    assign b_rd.rd_addr = b_off + B_AW'(col);

    assign c_wr.wr_en   = (state == ENG_WRITE);
    assign c_wr.wr_addr = c_idx;
    assign c_wr.wr_data = acc;

    assign ctrl.busy = (state != ENG_IDLE) && (state != ENG_DONE);
    assign ctrl.done = (state == ENG_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ENG_IDLE;
            k_q    <= '0;
            inner  <= '0;
            col    <= '0;
            c_idx  <= '0;
            a_row  <= '0;
            b_off  <= '0;
            rd_vld <= 1'b0;
        end else begin
            // data returns one cycle after the address was issued
            rd_vld <= (state == ENG_ISSUE);
            case (state)
                ENG_IDLE: begin
                    if (ctrl.start) begin
                        state <= ENG_ISSUE;
                        k_q   <= ctrl.k;
                        inner <= '0;
                        col   <= '0;
                        c_idx <= '0;
                        a_row <= '0;
                        b_off <= '0;
                    end
                end
                ENG_ISSUE: begin
                    if (inner == k_q - 1'b1) begin
                        state <= ENG_DRAIN;
                    end else begin
                        inner <= inner + 1'b1;
                        b_off <= b_off + B_AW'(N_COLS);
                    end
                end
                ENG_DRAIN: begin
                    state <= ENG_WRITE;
                end
                ENG_WRITE: begin
                    inner <= '0;
                    b_off <= '0;
                    c_idx <= c_idx + 1'b1;
                    if (col == C_AW'(N_COLS - 1)) begin
                        col   <= '0;
                        a_row <= a_row + A_AW'(k_q);
                    end else begin
                        col <= col + 1'b1;
                    end
                    if (c_idx == C_AW'(C_DEPTH - 1)) begin
                        state <= ENG_DONE;
                    end else begin
                        state <= ENG_ISSUE;
                    end
                end
                ENG_DONE: begin
                    state <= ENG_IDLE;
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // sum wraps at 32 bits, product is truncated the same way
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            acc <= acc + a_rd.rd_data * b_rd.rd_data;
        end else if (state == ENG_IDLE || state == ENG_WRITE) begin
            acc <= '0;
        end
    end

endmodule

/* design/mmm_matrix_ram.sv */
`timescale 1ns/1ps

module mmm_matrix_ram
    import mmm_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic   clk,
    mmm_ram_if.mem port
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_data;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        port.rd_data <= mem[port.rd_addr];
    end

endmodule

/* design/mmm_pkg.sv */
package mmm_pkg;

    localparam int DATA_W = 32;

    // matrix shape, k is chosen at run time up to MAX_K
    localparam int M_ROWS = 3;
    localparam int N_COLS = 5;
    localparam int MAX_K  = 6;
    localparam int K_W    = $clog2(MAX_K + 1);

    localparam int A_DEPTH = M_ROWS * MAX_K;
    localparam int B_DEPTH = MAX_K * N_COLS;
    localparam int C_DEPTH = M_ROWS * N_COLS;
    localparam int A_AW    = $clog2(A_DEPTH);
    localparam int B_AW    = $clog2(B_DEPTH);
    localparam int C_AW    = $clog2(C_DEPTH);

    localparam int AXI_AW = 12;

    // register offsets
    localparam logic [AXI_AW-1:0] REG_CTRL   = 12'h000;
    localparam logic [AXI_AW-1:0] REG_K      = 12'h004;
    localparam logic [AXI_AW-1:0] REG_STATUS = 12'h008;

    // matrix windows, one word per entry, row-major
    localparam logic [AXI_AW-1:0] A_BASE = 12'h100;
    localparam logic [AXI_AW-1:0] B_BASE = 12'h200;
    localparam logic [AXI_AW-1:0] C_BASE = 12'h300;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_ISSUE,
        ENG_DRAIN,
        ENG_WRITE,
        ENG_DONE
    } engine_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

/* design/mmm_ram_if.sv */
`timescale 1ns/1ps

interface mmm_ram_if
    import mmm_pkg::*;
#(
    parameter int AW = 4
) ();

    logic              wr_en;
    logic [AW-1:0]     wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [AW-1:0]     rd_addr;
    // valid one cycle after rd_addr
    logic [DATA_W-1:0] rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

    modport mem (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface

/* design/mmm_regs.sv */
`timescale 1ns/1ps

module mmm_regs
    import mmm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [AXI_AW-1:0] s_axi_awaddr,
    input  logic              s_axi_awvalid,
    output logic              s_axi_awready,
    input  logic [DATA_W-1:0] s_axi_wdata,
    input  logic              s_axi_wvalid,
    output logic              s_axi_wready,
    output logic [1:0]        s_axi_bresp,
    output logic              s_axi_bvalid,
    input  logic              s_axi_bready,
    input  logic [AXI_AW-1:0] s_axi_araddr,
    input  logic              s_axi_arvalid,
    output logic              s_axi_arready,
    output logic [DATA_W-1:0] s_axi_rdata,
    output logic [1:0]        s_axi_rresp,
    output logic              s_axi_rvalid,
    input  logic              s_axi_rready,
    mmm_ctrl_if.regs          ctrl,
    mmm_ram_if.writer         a_wr,
    mmm_ram_if.writer         b_wr,
    mmm_ram_if.reader         c_rd
);

    logic [K_W-1:0]    k_reg;
    logic              done_flag;
    logic              k_err;
    logic              rd_pend;
    logic              wr_fire;
    logic              rd_fire;
    logic              wr_ctrl, wr_k, wr_stat, wr_a, wr_b;
    logic              rd_c;
    logic [DATA_W-1:0] rd_word;
    axi_resp_e         wr_resp;
    axi_resp_e         rd_resp;

    function automatic logic in_win(input logic [AXI_AW-1:0] addr,
                                    input logic [AXI_AW-1:0] base,
                                    input int depth);
        return (addr[1:0] == 2'b00) && (addr >= base) &&
               (addr < base + AXI_AW'(4 * depth));
    endfunction

    function automatic logic [AXI_AW-3:0] win_idx(input logic [AXI_AW-1:0] addr,
                                                  input logic [AXI_AW-1:0] base);
        logic [AXI_AW-1:0] off;
        off = addr - base;
        return off[AXI_AW-1:2];
    endfunction

    assign ctrl.k = k_reg;
    assign wr_fire = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
    assign rd_fire = s_axi_arready && s_axi_arvalid;
    // C read port follows araddr, data lands in the cycle after the handshake
    assign c_rd.rd_addr = C_AW'(win_idx(s_axi_araddr, C_BASE));

    always_comb begin
        wr_ctrl = (s_axi_awaddr == REG_CTRL);
        wr_k    = (s_axi_awaddr == REG_K);
        wr_stat = (s_axi_awaddr == REG_STATUS);
        wr_a    = in_win(s_axi_awaddr, A_BASE, A_DEPTH);
        wr_b    = in_win(s_axi_awaddr, B_BASE, B_DEPTH);
        wr_resp = RESP_OKAY;
        if (!(wr_ctrl || wr_k || wr_stat || wr_a || wr_b)) begin
            wr_resp = RESP_SLVERR;
        end else if ((wr_a || wr_b) && ctrl.busy) begin
            wr_resp = RESP_SLVERR;
        end
    end

    // A and B windows are write-only, C is read-only
    always_comb begin
        rd_c    = in_win(s_axi_araddr, C_BASE, C_DEPTH);
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (s_axi_araddr)
            REG_CTRL:   rd_word = '0;
            REG_K:      rd_word = DATA_W'(k_reg);
            REG_STATUS: rd_word = DATA_W'({k_err, done_flag, ctrl.busy});
            default: begin
                if (!rd_c || ctrl.busy) begin
                    rd_resp = RESP_SLVERR;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            ctrl.start    <= 1'b0;
            a_wr.wr_en    <= 1'b0;
            b_wr.wr_en    <= 1'b0;
            k_reg         <= '0;
            done_flag     <= 1'b0;
            k_err         <= 1'b0;
        end else begin
            ctrl.start <= 1'b0;
            a_wr.wr_en <= 1'b0;
            b_wr.wr_en <= 1'b0;
            // accept address and data together, one write at a time
            s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
            s_axi_wready  <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
            if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            if (ctrl.done) begin
                done_flag <= 1'b1;
            end
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
                if (wr_ctrl && s_axi_wdata[0] && !ctrl.busy) begin
                    if (k_reg == '0 || k_reg > K_W'(MAX_K)) begin
                        k_err <= 1'b1;
                    end else begin
                        ctrl.start <= 1'b1;
                        done_flag  <= 1'b0;
                        k_err      <= 1'b0;
                    end
                end
                // k stays put during a run
                if (wr_k && !ctrl.busy) begin
                    k_reg <= s_axi_wdata[K_W-1:0];
                end
                a_wr.wr_en <= wr_a && !ctrl.busy;
                b_wr.wr_en <= wr_b && !ctrl.busy;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            s_axi_bresp  <= wr_resp;
            a_wr.wr_addr <= A_AW'(win_idx(s_axi_awaddr, A_BASE));
            a_wr.wr_data <= s_axi_wdata;
            b_wr.wr_addr <= B_AW'(win_idx(s_axi_awaddr, B_BASE));
            b_wr.wr_data <= s_axi_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            rd_pend       <= 1'b0;
        end else begin
            s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid && !rd_pend;
            if (s_axi_rvalid && s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
            if (rd_fire) begin
                if (rd_c && rd_resp == RESP_OKAY) begin
                    rd_pend <= 1'b1;
                end else begin
                    s_axi_rvalid <= 1'b1;
                end
            end
            if (rd_pend) begin
                rd_pend      <= 1'b0;
                s_axi_rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
            s_axi_rresp <= rd_resp;
        end else if (rd_pend) begin
            s_axi_rdata <= c_rd.rd_data;
        end
    end

endmodule

/* design/mmm_top.sv */
`timescale 1ns/1ps

module mmm_top
    import mmm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [AXI_AW-1:0] s_axi_awaddr,
    input  logic              s_axi_awvalid,
    output logic              s_axi_awready,
    input  logic [DATA_W-1:0] s_axi_wdata,
    input  logic              s_axi_wvalid,
    output logic              s_axi_wready,
    output logic [1:0]        s_axi_bresp,
    output logic              s_axi_bvalid,
    input  logic              s_axi_bready,
    input  logic [AXI_AW-1:0] s_axi_araddr,
    input  logic              s_axi_arvalid,
    output logic              s_axi_arready,
    output logic [DATA_W-1:0] s_axi_rdata,
    output logic [1:0]        s_axi_rresp,
    output logic              s_axi_rvalid,
    input  logic              s_axi_rready
);

    mmm_ctrl_if                  ctrl ();
    mmm_ram_if #(.AW(A_AW))      a_if ();
    mmm_ram_if #(.AW(B_AW))      b_if ();
    mmm_ram_if #(.AW(C_AW))      c_if ();

    mmm_regs regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .ctrl          (ctrl.regs),
        .a_wr          (a_if.writer),
        .b_wr          (b_if.writer),
        .c_rd          (c_if.reader)
    );

    mmm_engine engine_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl.engine),
        .a_rd  (a_if.reader),
        .b_rd  (b_if.reader),
        .c_wr  (c_if.writer)
    );

    mmm_matrix_ram #(.DEPTH(A_DEPTH)) a_ram (
        .clk  (clk),
        .port (a_if.mem)
    );

    mmm_matrix_ram #(.DEPTH(B_DEPTH)) b_ram (
        .clk  (clk),
        .port (b_if.mem)
    );

    mmm_matrix_ram #(.DEPTH(C_DEPTH)) c_ram (
        .clk  (clk),
        .port (c_if.mem)
    );

endmodule

/* project.f */
design/mmm_pkg.sv
design/mmm_ctrl_if.sv
design/mmm_ram_if.sv
design/mmm_matrix_ram.sv
design/mmm_regs.sv
design/mmm_engine.sv
design/mmm_top.sv
bench/mmm_chk.sv
bench/mmm_tb.sv
